/* include/read_pipe_defs.svh */
// sizes and widths of the tile read pipeline, include wherever a size is needed
`ifndef READ_PIPE_DEFS_SVH
`define READ_PIPE_DEFS_SVH

// ==================================================
// datapath widths
// ==================================================
`define RP_ADDR_BW 16
`define RP_COORD_BW 8
`define RP_DATA_BW 16

// elements per DRAM word, one word is one row
`define RP_CSIZE 4

// ==================================================
// tile geometry and buffering
// ==================================================
`define RP_TILE_ROWS 4
`define RP_N_SLOT 4

// DRAM words per image row
`define RP_PITCH 64

// derived
`define RP_SLOT_BW ($clog2(`RP_N_SLOT))
`define RP_ROW_BW ($clog2(`RP_TILE_ROWS))

`endif

/* rtl/rp_req_pkg.sv */
// request side types: tile request, row kind and per-row command
`include "read_pipe_defs.svh"

package rp_req_pkg;

	// ==================================================
	// tile request
	// ==================================================
	typedef struct packed {
		logic [`RP_ADDR_BW-1:0]  base;
		logic [`RP_COORD_BW-1:0] row0;
		logic [`RP_COORD_BW-1:0] col0;
		// rows at or beyond this are padding
		logic [`RP_COORD_BW-1:0] row_bound;
		logic [`RP_DATA_BW-1:0]  pad;
	} rp_tile_req_t;

	// ==================================================
	// row command
	// ==================================================
	typedef enum logic {
		ROW_FETCH,
		ROW_PAD
	} rp_row_kind_e;

	typedef struct packed {
		rp_row_kind_e            kind;
		logic [`RP_SLOT_BW-1:0]  slot;
		// final row of the tile
		logic                    last;
		logic [`RP_DATA_BW-1:0]  pad;
	} rp_row_cmd_t;

endpackage

/* rtl/rp_data_pkg.sv */
// data side types: one buffered row and one output row
`include "read_pipe_defs.svh"

package rp_data_pkg;

	// ==================================================
	// row payload
	// ==================================================
	// one DRAM word, element 0 in the low bits
	typedef struct packed {
		logic [`RP_CSIZE-1:0][`RP_DATA_BW-1:0] elem;
	} rp_row_data_t;

	// ==================================================
	// output row
	// ==================================================
	typedef struct packed {
		rp_row_data_t data;
		// set on the final row of a tile
		logic         last;
	} rp_row_out_t;

endpackage

/* rtl/chunk_head.sv */
// row loop of the read pipeline: takes tile requests, allocates slots, issues DRAM addresses
`include "read_pipe_defs.svh"

module chunk_head (
	input  logic                         i_clk,
	input  logic                         i_rst,
	// tile request
	input  logic                         i_req_rdy,
	output logic                         o_req_ack,
	input  rp_req_pkg::rp_tile_req_t     i_req,
	// DRAM read address
	output logic                         o_dramra_rdy,
	input  logic                         i_dramra_ack,
	output logic [`RP_ADDR_BW-1:0]       o_dramra,
	// row commands to the write collector
	output logic                         o_cmd_dval,
	output rp_req_pkg::rp_row_cmd_t      o_cmd,
	// slot released by the row buffer
	input  logic                         i_free_dval
);

	typedef enum logic {
		CH_IDLE,
		CH_RUN
	} ch_state_e;

	ch_state_e                   state;
	rp_req_pkg::rp_tile_req_t    req_r;
	logic [`RP_ROW_BW-1:0]       row_r;
	logic [`RP_SLOT_BW-1:0]      alloc_ptr;
	logic [`RP_SLOT_BW:0]        alloc_cnt;
	logic [`RP_COORD_BW:0]       cur_row;
	logic                        is_pad;
	logic                        is_last;
	logic                        can_alloc;
	logic                        cmd_fire;

	// ==================================================
	// row decode
	// ==================================================
	assign cur_row = req_r.row0 + row_r;
	// skip rows outside the boundary, no DRAM traffic for them
	assign is_pad = cur_row >= req_r.row_bound;
	assign is_last = row_r == `RP_ROW_BW'(`RP_TILE_ROWS - 1);
	assign can_alloc = alloc_cnt < `RP_N_SLOT;

	// base + (row0 + r) * pitch + col0
	assign o_dramra = req_r.base
		+ `RP_ADDR_BW'(cur_row) * `RP_ADDR_BW'(`RP_PITCH)
		+ `RP_ADDR_BW'(req_r.col0);

	assign o_req_ack = (state == CH_IDLE) && i_req_rdy;
	assign o_dramra_rdy = (state == CH_RUN) && can_alloc && !is_pad;

	// pad rows go out directly, fetch rows wait for the address ack
	assign cmd_fire = (state == CH_RUN) && can_alloc && (is_pad || i_dramra_ack);
	assign o_cmd_dval = cmd_fire;

	always_comb begin
		o_cmd.kind = is_pad ? rp_req_pkg::ROW_PAD : rp_req_pkg::ROW_FETCH;
		o_cmd.slot = alloc_ptr;
		o_cmd.last = is_last;
		o_cmd.pad = req_r.pad;
	end

	// ==================================================
	// sequential
	// ==================================================
	always_ff @(posedge i_clk) begin
		if (o_req_ack) begin
			req_r <= i_req;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state <= CH_IDLE;
			row_r <= '0;
		end else if (o_req_ack) begin
			state <= CH_RUN;
			row_r <= '0;
		end else if (cmd_fire) begin
			row_r <= row_r + 1'b1;
			if (is_last) begin
				state <= CH_IDLE;
			end
		end
	end

	// slots are handed out in cyclic order
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			alloc_ptr <= '0;
		end else if (cmd_fire) begin
			if (alloc_ptr == `RP_SLOT_BW'(`RP_N_SLOT - 1)) begin
				alloc_ptr <= '0;
			end else begin
				alloc_ptr <= alloc_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			alloc_cnt <= '0;
		end else if (cmd_fire && !i_free_dval) begin
			alloc_cnt <= alloc_cnt + 1'b1;
		end else if (!cmd_fire && i_free_dval) begin
			alloc_cnt <= alloc_cnt - 1'b1;
		end
	end

	// ==================================================
	// assertions
	// ==================================================
	assert property (@(posedge i_clk) disable iff (!i_rst) alloc_cnt <= `RP_N_SLOT)
		else $error("allocation count above slot limit");

	assert property (@(posedge i_clk) disable iff (!i_rst)
		o_dramra_rdy && !i_dramra_ack |=> o_dramra_rdy && $stable(o_dramra))
		else $error("DRAM address dropped or changed before ack");

endmodule

/* rtl/sram_write_collector.sv */
// queues row commands and fills buffer slots from DRAM data or with the pad value
`include "read_pipe_defs.svh"

module sram_write_collector (
	input  logic                         i_clk,
	input  logic                         i_rst,
	// row commands
	input  logic                         i_cmd_dval,
	input  rp_req_pkg::rp_row_cmd_t      i_cmd,
	// DRAM read data
	input  logic                         i_dramrd_rdy,
	output logic                         o_dramrd_ack,
	input  rp_data_pkg::rp_row_data_t    i_dramrd,
	// slot write
	output logic                         o_wr_dval,
	output logic [`RP_SLOT_BW-1:0]       o_wr_slot,
	output rp_data_pkg::rp_row_data_t    o_wr_data,
	output logic                         o_wr_last
);

	typedef enum logic [1:0] {
		SW_IDLE,
		SW_PAD,
		SW_FETCH
	} sw_state_e;

	sw_state_e                   state;
	rp_req_pkg::rp_row_cmd_t     cmd_mem [`RP_N_SLOT];
	logic [`RP_SLOT_BW-1:0]      wptr;
	logic [`RP_SLOT_BW-1:0]      rptr;
	logic [`RP_SLOT_BW-1:0]      rptr_nxt;
	logic [`RP_SLOT_BW:0]        fifo_cnt;
	rp_req_pkg::rp_row_cmd_t     head;
	sw_state_e                   head_mode;
	sw_state_e                   next_mode;
	rp_data_pkg::rp_row_data_t   pad_row;
	logic                        pop;
	logic                        wr_dval_r;

	// ==================================================
	// command FIFO
	// ==================================================
	assign head = cmd_mem[rptr];
	assign rptr_nxt = (rptr == `RP_SLOT_BW'(`RP_N_SLOT - 1)) ? '0 : rptr + 1'b1;
	assign head_mode = (head.kind == rp_req_pkg::ROW_PAD) ? SW_PAD : SW_FETCH;
	// kind of the entry behind the head, lets the FSM serve one row per cycle
	assign next_mode = (cmd_mem[rptr_nxt].kind == rp_req_pkg::ROW_PAD) ? SW_PAD : SW_FETCH;

	always_ff @(posedge i_clk) begin
		if (i_cmd_dval) begin
			cmd_mem[wptr] <= i_cmd;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wptr <= '0;
			rptr <= '0;
			fifo_cnt <= '0;
		end else begin
			if (i_cmd_dval) begin
				wptr <= (wptr == `RP_SLOT_BW'(`RP_N_SLOT - 1)) ? '0 : wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr_nxt;
			end
			fifo_cnt <= fifo_cnt + i_cmd_dval - pop;
		end
	end

	// ==================================================
	// head service
	// ==================================================
	assign o_dramrd_ack = (state == SW_FETCH) && i_dramrd_rdy;
	assign pop = (state == SW_PAD) || o_dramrd_ack;

	always_comb begin
		for (int k = 0; k < `RP_CSIZE; k++) begin
			pad_row.elem[k] = head.pad;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			state <= SW_IDLE;
		end else begin
			case (state)
				SW_IDLE: begin
					if (fifo_cnt != 0) begin
						state <= head_mode;
					end
				end
				default: begin
					if (pop) begin
						state <= (fifo_cnt > 1) ? next_mode : SW_IDLE;
					end
				end
			endcase
		end
	end

	// write goes out the cycle after the head is served
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			wr_dval_r <= 1'b0;
		end else begin
			wr_dval_r <= pop;
		end
	end

	always_ff @(posedge i_clk) begin
		if (pop) begin
			o_wr_slot <= head.slot;
			o_wr_last <= head.last;
			o_wr_data <= (state == SW_PAD) ? pad_row : i_dramrd;
		end
	end

	assign o_wr_dval = wr_dval_r;

	// chunk_head limits commands in flight to the FIFO depth
	assert property (@(posedge i_clk) disable iff (!i_rst)
		i_cmd_dval |-> fifo_cnt != `RP_N_SLOT)
		else $error("command FIFO written while full");

endmodule

/* rtl/row_buffer.sv */
// slot storage for finished rows, read out in allocation order on the SRAM read port
`include "read_pipe_defs.svh"

module row_buffer (
	input  logic                         i_clk,
	input  logic                         i_rst,
	// slot write from the collector
	input  logic                         i_wr_dval,
	input  logic [`RP_SLOT_BW-1:0]       i_wr_slot,
	input  rp_data_pkg::rp_row_data_t    i_wr_data,
	input  logic                         i_wr_last,
	// output rows
	output logic                         o_sramrd_rdy,
	input  logic                         i_sramrd_ack,
	output rp_data_pkg::rp_row_out_t     o_sramrd,
	// slot released
	output logic                         o_free_dval
);

	rp_data_pkg::rp_row_data_t   row_mem [`RP_N_SLOT];
	logic [`RP_N_SLOT-1:0]       last_r;
	logic [`RP_N_SLOT-1:0]       valid_r;
	logic [`RP_SLOT_BW-1:0]      rptr;
	logic                        rd_fire;

	// ==================================================
	// storage
	// ==================================================
	always_ff @(posedge i_clk) begin
		if (i_wr_dval) begin
			row_mem[i_wr_slot] <= i_wr_data;
			last_r[i_wr_slot] <= i_wr_last;
		end
	end

	// set and clear never hit the same slot
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			valid_r <= '0;
		end else begin
			if (i_wr_dval) begin
				valid_r[i_wr_slot] <= 1'b1;
			end
			if (rd_fire) begin
				valid_r[rptr] <= 1'b0;
			end
		end
	end

	// ==================================================
	// read-out
	// ==================================================
	assign o_sramrd_rdy = valid_r[rptr];
	assign rd_fire = o_sramrd_rdy && i_sramrd_ack;
	assign o_free_dval = rd_fire;

	always_comb begin
		o_sramrd.data = row_mem[rptr];
		o_sramrd.last = last_r[rptr];
	end

	// same cyclic order as allocation
	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			rptr <= '0;
		end else if (rd_fire) begin
			if (rptr == `RP_SLOT_BW'(`RP_N_SLOT - 1)) begin
				rptr <= '0;
			end else begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	assert property (@(posedge i_clk) disable iff (!i_rst)
		i_wr_dval |-> !valid_r[i_wr_slot])
		else $error("write into a slot that is still occupied");

endmodule

/* rtl/read_pipeline.sv */
// top of the tile read pipeline: row loop, write collector and row buffer
`include "read_pipe_defs.svh"

module read_pipeline (
	input  logic                         i_clk,
	input  logic                         i_rst,
	// tile request
	input  logic                         i_req_rdy,
	output logic                         o_req_ack,
	input  rp_req_pkg::rp_tile_req_t     i_req,
	// DRAM read address
	output logic                         o_dramra_rdy,
	input  logic                         i_dramra_ack,
	output logic [`RP_ADDR_BW-1:0]       o_dramra,
	// DRAM read data
	input  logic                         i_dramrd_rdy,
	output logic                         o_dramrd_ack,
	input  rp_data_pkg::rp_row_data_t    i_dramrd,
	// output rows
	output logic                         o_sramrd_rdy,
	input  logic                         i_sramrd_ack,
	output rp_data_pkg::rp_row_out_t     o_sramrd
);

	logic                        cmd_dval;
	rp_req_pkg::rp_row_cmd_t     cmd;
	logic                        wr_dval;
	logic [`RP_SLOT_BW-1:0]      wr_slot;
	rp_data_pkg::rp_row_data_t   wr_data;
	logic                        wr_last;
	logic                        free_dval;

	chunk_head u_chunk_head (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_req_rdy    (i_req_rdy),
		.o_req_ack    (o_req_ack),
		.i_req        (i_req),
		.o_dramra_rdy (o_dramra_rdy),
		.i_dramra_ack (i_dramra_ack),
		.o_dramra     (o_dramra),
		.o_cmd_dval   (cmd_dval),
		.o_cmd        (cmd),
		.i_free_dval  (free_dval)
	);

	sram_write_collector u_swc (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_cmd_dval   (cmd_dval),
		.i_cmd        (cmd),
		.i_dramrd_rdy (i_dramrd_rdy),
		.o_dramrd_ack (o_dramrd_ack),
		.i_dramrd     (i_dramrd),
		.o_wr_dval    (wr_dval),
		.o_wr_slot    (wr_slot),
		.o_wr_data    (wr_data),
		.o_wr_last    (wr_last)
	);

	row_buffer u_row_buffer (
		.i_clk        (i_clk),
		.i_rst        (i_rst),
		.i_wr_dval    (wr_dval),
		.i_wr_slot    (wr_slot),
		.i_wr_data    (wr_data),
		.i_wr_last    (wr_last),
		.o_sramrd_rdy (o_sramrd_rdy),
		.i_sramrd_ack (i_sramrd_ack),
		.o_sramrd     (o_sramrd),
		.o_free_dval  (free_dval)
	);

endmodule

/* tests/read_pipeline_tb.sv */
// testbench for the tile read pipeline, run as top module read_pipeline_tb with read_pipeline.f
`include "read_pipe_defs.svh"

module read_pipeline_tb;

	localparam int WAIT_LIMIT = 3000;

	logic                        i_clk;
	logic                        i_rst;
	logic                        i_req_rdy;
	logic                        o_req_ack;
	rp_req_pkg::rp_tile_req_t    i_req;
	logic                        o_dramra_rdy;
	logic                        i_dramra_ack;
	logic [`RP_ADDR_BW-1:0]      o_dramra;
	logic                        i_dramrd_rdy;
	logic                        o_dramrd_ack;
	rp_data_pkg::rp_row_data_t   i_dramrd;
	logic                        o_sramrd_rdy;
	logic                        i_sramrd_ack;
	rp_data_pkg::rp_row_out_t    o_sramrd;

	// expected traffic, DRAM model queue and queue heads seen by the checks
	logic [`RP_ADDR_BW-1:0]      exp_addr [$];
	rp_data_pkg::rp_row_out_t    exp_row [$];
	logic [`RP_ADDR_BW-1:0]      dram_q [$];
	logic [`RP_ADDR_BW-1:0]      addr_head;
	rp_data_pkg::rp_row_out_t    row_head;
	logic                        addr_any;
	logic                        row_any;
	int                          addr_acked;
	int                          rows_taken;
	int                          stall_pct;
	logic                        hold_out;

	string                       test_name;
	int                          err_cnt;
	int                          start_errs;
	int                          passes;
	int                          fails;
	logic                        hung;

	read_pipeline read_pipeline_i (.*);

	initial i_clk = 1'b0;
	always #50 i_clk = ~i_clk;

	// ==================================================
	// checks
	// ==================================================
	assert property (@(posedge i_clk) disable iff (!i_rst)
		o_dramra_rdy && i_dramra_ack |-> addr_any && o_dramra == addr_head)
	else begin
		err_cnt++;
		if ($sampled(addr_any)) begin
			$display("Mismatch in %s: expected address %h, actual %h", test_name,
				$sampled(addr_head), $sampled(o_dramra));
		end else begin
			$display("%s: DRAM address %h issued where no read was expected", test_name,
				$sampled(o_dramra));
		end
	end

	assert property (@(posedge i_clk) disable iff (!i_rst)
		o_sramrd_rdy && i_sramrd_ack |-> row_any && o_sramrd == row_head)
	else begin
		err_cnt++;
		if ($sampled(row_any)) begin
			$display("Mismatch in %s: expected row %h, actual %h", test_name,
				$sampled(row_head), $sampled(o_sramrd));
		end else begin
			$display("%s: output row %h delivered with none expected", test_name,
				$sampled(o_sramrd));
		end
	end

	// reads in flight never outrun the buffer slots
	assert property (@(posedge i_clk) disable iff (!i_rst)
		addr_acked - rows_taken <= `RP_N_SLOT)
	else begin
		err_cnt++;
		$display("%s: %0d DRAM reads ahead of the taken rows, more than the slot count",
			test_name, $sampled(addr_acked) - $sampled(rows_taken));
	end

	// ==================================================
	// reference model
	// ==================================================
	function automatic rp_data_pkg::rp_row_data_t dram_word(input logic [`RP_ADDR_BW-1:0] addr);
		rp_data_pkg::rp_row_data_t w;
		for (int k = 0; k < `RP_CSIZE; k++) begin
			w.elem[k] = `RP_DATA_BW'(addr + k);
		end
		return w;
	endfunction

	function automatic rp_req_pkg::rp_tile_req_t make_req(input int base, input int row0,
		input int col0, input int bound, input int pad);
		rp_req_pkg::rp_tile_req_t req;
		req.base = `RP_ADDR_BW'(base);
		req.row0 = `RP_COORD_BW'(row0);
		req.col0 = `RP_COORD_BW'(col0);
		req.row_bound = `RP_COORD_BW'(bound);
		req.pad = `RP_DATA_BW'(pad);
		return req;
	endfunction

	task automatic push_expected(input rp_req_pkg::rp_tile_req_t req);
		rp_data_pkg::rp_row_out_t row;
		logic [`RP_ADDR_BW-1:0] addr;
		int abs_row;
		for (int r = 0; r < `RP_TILE_ROWS; r++) begin
			abs_row = int'(req.row0) + r;
			row.last = (r == `RP_TILE_ROWS - 1);
			if (abs_row < int'(req.row_bound)) begin
				addr = `RP_ADDR_BW'(int'(req.base) + abs_row * `RP_PITCH + int'(req.col0));
				exp_addr.push_back(addr);
				row.data = dram_word(addr);
			end else begin
				for (int k = 0; k < `RP_CSIZE; k++) begin
					row.data.elem[k] = req.pad;
				end
			end
			exp_row.push_back(row);
		end
	endtask

	// ==================================================
	// bus models
	// ==================================================
	function automatic logic rand_go();
		return ($urandom % 100) >= stall_pct;
	endfunction

	// DRAM model and ack generation for all four streams
	task automatic run_bus_models();
		forever begin
			@(posedge i_clk);
			if (o_dramra_rdy && i_dramra_ack) begin
				if (exp_addr.size() > 0) begin
					void'(exp_addr.pop_front());
				end
				dram_q.push_back(o_dramra);
				addr_acked++;
			end
			if (o_sramrd_rdy && i_sramrd_ack) begin
				if (exp_row.size() > 0) begin
					void'(exp_row.pop_front());
				end
				rows_taken++;
			end
			// DRAM returns data in address order
			if (!i_dramrd_rdy || o_dramrd_ack) begin
				if (dram_q.size() > 0 && rand_go()) begin
					i_dramrd <= dram_word(dram_q.pop_front());
					i_dramrd_rdy <= 1'b1;
				end else begin
					i_dramrd_rdy <= 1'b0;
				end
			end
			i_dramra_ack <= o_dramra_rdy && !i_dramra_ack && rand_go();
			i_sramrd_ack <= o_sramrd_rdy && !i_sramrd_ack && !hold_out && rand_go();
			addr_any = exp_addr.size() > 0;
			row_any = exp_row.size() > 0;
			if (addr_any) begin
				addr_head = exp_addr[0];
			end
			if (row_any) begin
				row_head = exp_row[0];
			end
		end
	endtask

	// ==================================================
	// stimulus helpers
	// ==================================================
	task automatic send_tile(input rp_req_pkg::rp_tile_req_t req);
		int n;
		logic acked;
		push_expected(req);
		@(posedge i_clk);
		i_req <= req;
		i_req_rdy <= 1'b1;
		n = 0;
		acked = 1'b0;
		while (!acked && n < WAIT_LIMIT) begin
			@(posedge i_clk);
			acked = o_req_ack;
			n++;
		end
		i_req_rdy <= 1'b0;
		if (!acked) begin
			hung = 1'b1;
			err_cnt++;
			$display("%s: request was never acknowledged", test_name);
		end
	endtask

	task automatic wait_drain();
		int n;
		n = 0;
		while ((exp_addr.size() > 0 || exp_row.size() > 0) && n < WAIT_LIMIT) begin
			@(negedge i_clk);
			n++;
		end
		if (exp_addr.size() > 0 || exp_row.size() > 0) begin
			hung = 1'b1;
			err_cnt++;
			$display("%s: gave up with %0d output rows still missing", test_name,
				exp_row.size());
		end
	endtask

	task automatic begin_test(input string name, input int pct);
		test_name = name;
		start_errs = err_cnt;
		stall_pct <= pct;
		// pipeline is empty here, reads in flight count from zero
		addr_acked = 0;
		rows_taken = 0;
	endtask

	task automatic end_test();
		if (err_cnt == start_errs) begin
			passes++;
			$display("%-22s ok", test_name);
		end else begin
			fails++;
			$display("%-22s FAIL (%0d errors)", test_name, err_cnt - start_errs);
		end
	endtask

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		int r0;
		i_rst <= 1'b0;
		i_req_rdy <= 1'b0;
		i_req <= '0;
		i_dramra_ack <= 1'b0;
		i_dramrd_rdy <= 1'b0;
		i_dramrd <= '0;
		i_sramrd_ack <= 1'b0;
		err_cnt = 0;
		passes = 0;
		fails = 0;
		hung = 1'b0;
		addr_acked = 0;
		rows_taken = 0;
		stall_pct = 0;
		hold_out = 1'b0;
		addr_any = 1'b0;
		row_any = 1'b0;
		test_name = "reset";
		void'($urandom(33));
		fork
			run_bus_models();
		join_none
		repeat (8) @(posedge i_clk);
		i_rst <= 1'b1;

		begin_test("in_bounds_tile", 0);
		send_tile(make_req('h0100, 2, 5, 40, 'hdead));
		wait_drain();
		end_test();

		if (!hung) begin
			// rows 10 and 11 fetched, 12 and 13 padded
			begin_test("partial_bound", 0);
			send_tile(make_req('h0400, 10, 3, 12, 'hbeef));
			wait_drain();
			end_test();
		end

		if (!hung) begin
			begin_test("fully_padded", 0);
			send_tile(make_req('h0800, 30, 7, 30, 'h5a5a));
			wait_drain();
			end_test();
		end

		if (!hung) begin
			begin_test("back_to_back_stalls", 40);
			for (int t = 0; t < 6 && !hung; t++) begin
				r0 = $urandom % 60;
				send_tile(make_req($urandom, r0, $urandom % 64, r0 + $urandom % 6, $urandom));
			end
			wait_drain();
			end_test();
		end

		if (!hung) begin
			begin_test("output_backpressure", 20);
			hold_out <= 1'b1;
			send_tile(make_req('h1200, 1, 9, 50, 'h1111));
			send_tile(make_req('h2300, 5, 2, 7, 'h2222));
			// second tile waits behind full slots during the hold
			repeat (60) @(posedge i_clk);
			hold_out <= 1'b0;
			wait_drain();
			end_test();
		end

		$display("tests run %0d, passed %0d, failed %0d", passes + fails, passes, fails);
		if (fails == 0 && err_cnt == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* read_pipeline.f */
+incdir+include
rtl/rp_req_pkg.sv
rtl/rp_data_pkg.sv
rtl/chunk_head.sv
rtl/sram_write_collector.sv
rtl/row_buffer.sv
rtl/read_pipeline.sv
tests/read_pipeline_tb.sv

/* Bender.yml */
package:
  name: read_pipeline

sources:
  - include_dirs:
      - include
    files:
      - rtl/rp_req_pkg.sv
      - rtl/rp_data_pkg.sv
      - rtl/chunk_head.sv
      - rtl/sram_write_collector.sv
      - rtl/row_buffer.sv
      - rtl/read_pipeline.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/read_pipeline_tb.sv
